// File: hw/ifm_pkg.sv
// Receive ingress buffer shared types, FIFO sizes and filter states
`default_nettype none

package ifm_pkg;

   // Stream payload fields
   typedef logic [63:0] tdata_t;
   typedef logic [7:0]  tkeep_t;

   // One data beat as {last, keep, data}
   typedef logic [72:0] beat_t;

   // MAC info byte, zero marks a good frame
   typedef logic [7:0]  info_t;

   // Status word as {info code, beats mod 256, bytes}
   typedef logic [31:0] stat_data_t;

   // Status FIFO entry as {last, keep, word}
   typedef logic [36:0] stat_t;

   // Frame byte count
   typedef logic [15:0] len_t;

   // Data FIFO, rx_clk to s2mm_clk
   localparam int data_depth_log2  = 9;
   localparam int data_afull_level = 480;

   // Info FIFO, one entry per frame
   localparam int info_depth_log2  = 8;

   // Packet and status FIFOs in s2mm_clk
   localparam int pkt_depth_log2   = 9;
   localparam int pkt_afull_level  = 480;
   localparam int stat_depth_log2  = 9;
   localparam int stat_afull_level = 480;

   // Frame filter FSM
   typedef enum logic [1:0] {
      filt_idle,
      filt_copy,
      filt_drop,
      filt_status
   } filt_state_t;

endpackage

`default_nettype wire

// File: hw/async_fifo.sv
// Dual-clock first-word-fall-through FIFO with Gray pointers and almost-full flag
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
   parameter int width       = 8,
   parameter int depth_log2  = 4,
   parameter int afull_level = 12
) (
   // Write side
   input  wire              wclk,
   input  wire              wrst_n,
   input  wire              winc,
   input  wire [width-1:0]  wdata,
   output logic             wafull,
   // Read side
   input  wire              rclk,
   input  wire              rrst_n,
   input  wire              rinc,
   output logic [width-1:0] rdata,
   output logic             rempty
);

   localparam int depth = 1 << depth_log2;

   logic [width-1:0]    mem [depth];

   // Reset release per domain
   logic [1:0]          wrst_sync;
   logic [1:0]          rrst_sync;
   logic                wrst_s;
   logic                rrst_s;

   // Pointers carry one extra wrap bit
   logic [depth_log2:0] wbin;
   logic [depth_log2:0] wbin_next;
   logic [depth_log2:0] wgray;
   logic [depth_log2:0] rbin;
   logic [depth_log2:0] rbin_next;
   logic [depth_log2:0] rgray;

   // Crossing synchronizers
   logic [depth_log2:0] wq1_rgray;
   logic [depth_log2:0] wq2_rgray;
   logic [depth_log2:0] rq1_wgray;
   logic [depth_log2:0] rq2_wgray;

   logic [depth_log2:0] wcount;
   logic                wfull;
   logic                wwrite;
   logic                rread;

   function automatic logic [depth_log2:0] gray2bin(input logic [depth_log2:0] g);
      logic [depth_log2:0] b;
      b[depth_log2] = g[depth_log2];
      for (int i = depth_log2 - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write domain reset release
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         wrst_sync <= 2'b00;
      end else begin
         wrst_sync <= {wrst_sync[0], 1'b1};
      end
   end
   assign wrst_s = wrst_sync[1];

   // Read domain reset release
   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         rrst_sync <= 2'b00;
      end else begin
         rrst_sync <= {rrst_sync[0], 1'b1};
      end
   end
   assign rrst_s = rrst_sync[1];

   // Occupancy seen from the write side, read pointer lags by two cycles
   assign wcount    = wbin - gray2bin(wq2_rgray);
   assign wfull     = wcount[depth_log2];
   assign wafull    = wcount >= (depth_log2 + 1)'(afull_level);
   assign wwrite    = winc && !wfull;
   assign wbin_next = wbin + {{depth_log2{1'b0}}, wwrite};

   always_ff @(posedge wclk or negedge wrst_s) begin
      if (!wrst_s) begin
         wbin      <= '0;
         wgray     <= '0;
         wq1_rgray <= '0;
         wq2_rgray <= '0;
      end else begin
         wbin      <= wbin_next;
         wgray     <= (wbin_next >> 1) ^ wbin_next;
         wq1_rgray <= rgray;
         wq2_rgray <= wq1_rgray;
      end
   end

   // Storage, no reset
   always_ff @(posedge wclk) begin
      if (wwrite) begin
         mem[wbin[depth_log2-1:0]] <= wdata;
      end
   end

   // Empty when pointers match, head word falls through
   assign rempty    = rgray == rq2_wgray;
   assign rread     = rinc && !rempty;
   assign rbin_next = rbin + {{depth_log2{1'b0}}, rread};
   assign rdata     = mem[rbin[depth_log2-1:0]];

   always_ff @(posedge rclk or negedge rrst_s) begin
      if (!rrst_s) begin
         rbin      <= '0;
         rgray     <= '0;
         rq1_wgray <= '0;
         rq2_wgray <= '0;
      end else begin
         rbin      <= rbin_next;
         rgray     <= (rbin_next >> 1) ^ rbin_next;
         rq1_wgray <= wgray;
         rq2_wgray <= rq1_wgray;
      end
   end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
// Single-clock first-word-fall-through FIFO with almost-full flag
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int width       = 8,
   parameter int depth_log2  = 4,
   parameter int afull_level = 12
) (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              wr_en,
   input  wire [width-1:0]  din,
   input  wire              rd_en,
   output logic [width-1:0] dout,
   output logic             empty,
   output logic             afull
);

   localparam int depth = 1 << depth_log2;

   logic [width-1:0]      mem [depth];
   logic [depth_log2-1:0] wptr;
   logic [depth_log2-1:0] rptr;
   // One bit wider to hold a full count
   logic [depth_log2:0]   count;
   logic                  full;
   logic                  push;
   logic                  pop;

   assign full  = count[depth_log2];
   assign empty = count == '0;
   assign afull = count >= (depth_log2 + 1)'(afull_level);

   // Guard against overflow and underflow
   assign push  = wr_en && !full;
   assign pop   = rd_en && !empty;

   // Head word shows while not empty
   assign dout  = mem[rptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr <= rptr + 1'b1;
         end
         // Simultaneous push and pop keeps the count
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= din;
      end
   end

endmodule

`default_nettype wire

// File: hw/ifm_fifo.sv
// Ingress FIFO bank, unpacks the packet and status FIFOs into the rxd and rxs streams
`timescale 1ns/1ps
`default_nettype none

module ifm_fifo (
   input  wire                       rx_clk,
   input  wire                       s2mm_clk,
   input  wire                       rst_n,
   // Data FIFO
   input  wire ifm_pkg::beat_t       data_fifo_wdata,
   input  wire                       data_fifo_wren,
   input  wire                       data_fifo_rden,
   output ifm_pkg::beat_t            data_fifo_rdata,
   output logic                      data_fifo_afull,
   // Info FIFO
   input  wire ifm_pkg::info_t       info_fifo_wdata,
   input  wire                       info_fifo_wren,
   input  wire                       info_fifo_rden,
   output ifm_pkg::info_t            info_fifo_rdata,
   output logic                      info_fifo_empty,
   // Packet FIFO
   input  wire ifm_pkg::beat_t       good_fifo_wdata,
   input  wire                       good_fifo_wren,
   output logic                      good_fifo_afull,
   // Status FIFO
   input  wire ifm_pkg::stat_t       ctrl_fifo_wdata,
   input  wire                       ctrl_fifo_wren,
   output logic                      ctrl_fifo_afull,
   // Streams
   input  wire                       rxd_tready,
   input  wire                       rxs_tready,
   output ifm_pkg::tdata_t           rxd_tdata,
   output ifm_pkg::tkeep_t           rxd_tkeep,
   output logic                      rxd_tlast,
   output logic                      rxd_tvalid,
   output ifm_pkg::stat_data_t       rxs_tdata,
   output logic [3:0]                rxs_tkeep,
   output logic                      rxs_tlast,
   output logic                      rxs_tvalid
);

   ifm_pkg::beat_t good_fifo_rdata;
   logic           good_fifo_empty;
   logic           good_fifo_rden;
   ifm_pkg::stat_t ctrl_fifo_rdata;
   logic           ctrl_fifo_empty;
   logic           ctrl_fifo_rden;

   // Frame beats cross from rx_clk, empty not needed since info trails data
   async_fifo #(
      .width       ($bits(ifm_pkg::beat_t)),
      .depth_log2  (ifm_pkg::data_depth_log2),
      .afull_level (ifm_pkg::data_afull_level)
   ) u_data_fifo (
      .wclk   (rx_clk),
      .wrst_n (rst_n),
      .winc   (data_fifo_wren),
      .wdata  (data_fifo_wdata),
      .wafull (data_fifo_afull),
      .rclk   (s2mm_clk),
      .rrst_n (rst_n),
      .rinc   (data_fifo_rden),
      .rdata  (data_fifo_rdata),
      .rempty ()
   );

   // One info byte per frame, never close to full
   async_fifo #(
      .width       ($bits(ifm_pkg::info_t)),
      .depth_log2  (ifm_pkg::info_depth_log2),
      .afull_level (1 << ifm_pkg::info_depth_log2)
   ) u_info_fifo (
      .wclk   (rx_clk),
      .wrst_n (rst_n),
      .winc   (info_fifo_wren),
      .wdata  (info_fifo_wdata),
      .wafull (),
      .rclk   (s2mm_clk),
      .rrst_n (rst_n),
      .rinc   (info_fifo_rden),
      .rdata  (info_fifo_rdata),
      .rempty (info_fifo_empty)
   );

   // Good frames only
   sync_fifo #(
      .width       ($bits(ifm_pkg::beat_t)),
      .depth_log2  (ifm_pkg::pkt_depth_log2),
      .afull_level (ifm_pkg::pkt_afull_level)
   ) u_good_fifo (
      .clk   (s2mm_clk),
      .rst_n (rst_n),
      .wr_en (good_fifo_wren),
      .din   (good_fifo_wdata),
      .rd_en (good_fifo_rden),
      .dout  (good_fifo_rdata),
      .empty (good_fifo_empty),
      .afull (good_fifo_afull)
   );

   // Beat {last, keep, data} onto rxd
   assign rxd_tdata      = good_fifo_rdata[63:0];
   assign rxd_tkeep      = good_fifo_rdata[71:64];
   assign rxd_tlast      = good_fifo_rdata[72];
   assign rxd_tvalid     = !good_fifo_empty;
   assign good_fifo_rden = rxd_tvalid && rxd_tready;

   // One status word per frame
   sync_fifo #(
      .width       ($bits(ifm_pkg::stat_t)),
      .depth_log2  (ifm_pkg::stat_depth_log2),
      .afull_level (ifm_pkg::stat_afull_level)
   ) u_ctrl_fifo (
      .clk   (s2mm_clk),
      .rst_n (rst_n),
      .wr_en (ctrl_fifo_wren),
      .din   (ctrl_fifo_wdata),
      .rd_en (ctrl_fifo_rden),
      .dout  (ctrl_fifo_rdata),
      .empty (ctrl_fifo_empty),
      .afull (ctrl_fifo_afull)
   );

   // Entry {last, keep, word} onto rxs
   assign rxs_tdata      = ctrl_fifo_rdata[31:0];
   assign rxs_tkeep      = ctrl_fifo_rdata[35:32];
   assign rxs_tlast      = ctrl_fifo_rdata[36];
   assign rxs_tvalid     = !ctrl_fifo_empty;
   assign ctrl_fifo_rden = rxs_tvalid && rxs_tready;

endmodule

`default_nettype wire

// File: hw/ifm_frame_filter.sv
// Frame filter, copies good frames to the packet FIFO, drops bad ones, writes status
`timescale 1ns/1ps
`default_nettype none

module ifm_frame_filter (
   input  wire                  s2mm_clk,
   input  wire                  rst_n,
   // Info FIFO read side
   input  wire                  info_fifo_empty,
   input  wire ifm_pkg::info_t  info_fifo_rdata,
   output logic                 info_fifo_rden,
   // Data FIFO read side
   input  wire ifm_pkg::beat_t  data_fifo_rdata,
   output logic                 data_fifo_rden,
   // Packet FIFO write side
   input  wire                  good_fifo_afull,
   output ifm_pkg::beat_t       good_fifo_wdata,
   output logic                 good_fifo_wren,
   // Status FIFO write side
   input  wire                  ctrl_fifo_afull,
   output ifm_pkg::stat_t       ctrl_fifo_wdata,
   output logic                 ctrl_fifo_wren
);

   ifm_pkg::filt_state_t state;
   // Info code of the frame in flight
   ifm_pkg::info_t       code;
   logic [7:0]           beat_cnt;
   ifm_pkg::len_t        byte_cnt;
   ifm_pkg::stat_data_t  stat_word;
   logic                 beat_last;
   logic [3:0]           beat_bytes;

   // Set keep bits in one beat
   function automatic logic [3:0] keep_count(input ifm_pkg::tkeep_t keep);
      logic [3:0] n;
      n = 4'd0;
      for (int i = 0; i < $bits(ifm_pkg::tkeep_t); i++) begin
         n = n + {3'b000, keep[i]};
      end
      return n;
   endfunction

   assign beat_last  = data_fifo_rdata[72];
   assign beat_bytes = keep_count(data_fifo_rdata[71:64]);

   // Copy pops only with room downstream, drop never stalls
   assign good_fifo_wren  = (state == ifm_pkg::filt_copy) && !good_fifo_afull;
   assign data_fifo_rden  = good_fifo_wren || (state == ifm_pkg::filt_drop);
   // Beat passes through unchanged
   assign good_fifo_wdata = data_fifo_rdata;

   // Status entry, keep all ones and last set
   assign stat_word       = {code, beat_cnt, byte_cnt};
   assign ctrl_fifo_wren  = (state == ifm_pkg::filt_status) && !ctrl_fifo_afull;
   assign ctrl_fifo_wdata = {1'b1, 4'hf, stat_word};

   always_ff @(posedge s2mm_clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= ifm_pkg::filt_idle;
         info_fifo_rden <= 1'b0;
         beat_cnt       <= '0;
         byte_cnt       <= '0;
      end else begin
         // Info pop is a single cycle strobe
         info_fifo_rden <= 1'b0;
         case (state)
            ifm_pkg::filt_idle: begin
               beat_cnt <= '0;
               byte_cnt <= '0;
               // Info visible means the whole frame is already buffered
               if (!info_fifo_empty) begin
                  info_fifo_rden <= 1'b1;
                  if (info_fifo_rdata == '0) begin
                     state <= ifm_pkg::filt_copy;
                  end else begin
                     state <= ifm_pkg::filt_drop;
                  end
               end
            end
            ifm_pkg::filt_copy,
            ifm_pkg::filt_drop: begin
               // Counts cover dropped frames as well
               if (data_fifo_rden) begin
                  beat_cnt <= beat_cnt + 8'd1;
                  byte_cnt <= byte_cnt + {12'd0, beat_bytes};
                  if (beat_last) begin
                     state <= ifm_pkg::filt_status;
                  end
               end
            end
            ifm_pkg::filt_status: begin
               // Hold until the status FIFO has room
               if (ctrl_fifo_wren) begin
                  state <= ifm_pkg::filt_idle;
               end
            end
            default: begin
               state <= ifm_pkg::filt_idle;
            end
         endcase
      end
   end

   // Latch the code as the info byte is taken
   always_ff @(posedge s2mm_clk) begin
      if (state == ifm_pkg::filt_idle && !info_fifo_empty) begin
         code <= info_fifo_rdata;
      end
   end

endmodule

`default_nettype wire

// File: hw/ifm_rx_top.sv
// Receive ingress top, FIFO bank plus frame filter
`timescale 1ns/1ps
`default_nettype none

module ifm_rx_top (
   input  wire                      rx_clk,
   input  wire                      s2mm_clk,
   input  wire                      rst_n,
   // rx side writes
   input  wire ifm_pkg::beat_t      data_fifo_wdata,
   input  wire                      data_fifo_wren,
   input  wire ifm_pkg::info_t      info_fifo_wdata,
   input  wire                      info_fifo_wren,
   output wire                      data_fifo_afull,
   // Data stream
   output wire ifm_pkg::tdata_t     rxd_tdata,
   output wire ifm_pkg::tkeep_t     rxd_tkeep,
   output wire                      rxd_tlast,
   output wire                      rxd_tvalid,
   input  wire                      rxd_tready,
   // Status stream
   output wire ifm_pkg::stat_data_t rxs_tdata,
   output wire [3:0]                rxs_tkeep,
   output wire                      rxs_tlast,
   output wire                      rxs_tvalid,
   input  wire                      rxs_tready
);

   // Filter to FIFO bank, all in s2mm_clk
   ifm_pkg::info_t info_fifo_rdata;
   logic           info_fifo_empty;
   logic           info_fifo_rden;
   ifm_pkg::beat_t data_fifo_rdata;
   logic           data_fifo_rden;
   ifm_pkg::beat_t good_fifo_wdata;
   logic           good_fifo_wren;
   logic           good_fifo_afull;
   ifm_pkg::stat_t ctrl_fifo_wdata;
   logic           ctrl_fifo_wren;
   logic           ctrl_fifo_afull;

   ifm_fifo u_fifo (
      .rx_clk          (rx_clk),
      .s2mm_clk        (s2mm_clk),
      .rst_n           (rst_n),
      .data_fifo_wdata (data_fifo_wdata),
      .data_fifo_wren  (data_fifo_wren),
      .data_fifo_rden  (data_fifo_rden),
      .data_fifo_rdata (data_fifo_rdata),
      .data_fifo_afull (data_fifo_afull),
      .info_fifo_wdata (info_fifo_wdata),
      .info_fifo_wren  (info_fifo_wren),
      .info_fifo_rden  (info_fifo_rden),
      .info_fifo_rdata (info_fifo_rdata),
      .info_fifo_empty (info_fifo_empty),
      .good_fifo_wdata (good_fifo_wdata),
      .good_fifo_wren  (good_fifo_wren),
      .good_fifo_afull (good_fifo_afull),
      .ctrl_fifo_wdata (ctrl_fifo_wdata),
      .ctrl_fifo_wren  (ctrl_fifo_wren),
      .ctrl_fifo_afull (ctrl_fifo_afull),
      .rxd_tready      (rxd_tready),
      .rxs_tready      (rxs_tready),
      .rxd_tdata       (rxd_tdata),
      .rxd_tkeep       (rxd_tkeep),
      .rxd_tlast       (rxd_tlast),
      .rxd_tvalid      (rxd_tvalid),
      .rxs_tdata       (rxs_tdata),
      .rxs_tkeep       (rxs_tkeep),
      .rxs_tlast       (rxs_tlast),
      .rxs_tvalid      (rxs_tvalid)
   );

   ifm_frame_filter u_filter (
      .s2mm_clk        (s2mm_clk),
      .rst_n           (rst_n),
      .info_fifo_empty (info_fifo_empty),
      .info_fifo_rdata (info_fifo_rdata),
      .info_fifo_rden  (info_fifo_rden),
      .data_fifo_rdata (data_fifo_rdata),
      .data_fifo_rden  (data_fifo_rden),
      .good_fifo_afull (good_fifo_afull),
      .good_fifo_wdata (good_fifo_wdata),
      .good_fifo_wren  (good_fifo_wren),
      .ctrl_fifo_afull (ctrl_fifo_afull),
      .ctrl_fifo_wdata (ctrl_fifo_wdata),
      .ctrl_fifo_wren  (ctrl_fifo_wren)
   );

endmodule

`default_nettype wire

// File: test/ifm_asserts.sv
// Bound checks on the rxd and rxs streams and the filter's packet FIFO writes
`timescale 1ns/1ps
`default_nettype none

module ifm_asserts (
   input wire                      s2mm_clk,
   input wire                      rst_n,
   input wire ifm_pkg::tdata_t     rxd_tdata,
   input wire ifm_pkg::tkeep_t     rxd_tkeep,
   input wire                      rxd_tlast,
   input wire                      rxd_tvalid,
   input wire                      rxd_tready,
   input wire ifm_pkg::stat_data_t rxs_tdata,
   input wire                      rxs_tvalid,
   input wire                      rxs_tready,
   input wire                      good_fifo_wren,
   input wire                      good_fifo_afull
);

   // Failed assertions so far
   int unsigned fail_count = 0;

   // Stalled rxd beat holds
   a_rxd_hold: assert property (@(posedge s2mm_clk) disable iff (!rst_n)
      rxd_tvalid && !rxd_tready |=> rxd_tvalid && $stable(rxd_tdata) && $stable(rxd_tkeep)
         && $stable(rxd_tlast))
      else begin
         fail_count++;
         $error("rxd changed while stalled");
      end

   // Stalled status word holds
   a_rxs_hold: assert property (@(posedge s2mm_clk) disable iff (!rst_n)
      rxs_tvalid && !rxs_tready |=> rxs_tvalid && $stable(rxs_tdata))
      else begin
         fail_count++;
         $error("rxs changed while stalled");
      end

   a_reset_quiet: assert property (@(posedge s2mm_clk) !rst_n |-> !rxd_tvalid && !rxs_tvalid)
      else begin
         fail_count++;
         $error("stream valid during reset");
      end

   // No packet FIFO write past the almost-full level
   a_good_room: assert property (@(posedge s2mm_clk) disable iff (!rst_n)
      good_fifo_afull |-> !good_fifo_wren)
      else begin
         fail_count++;
         $error("packet FIFO written while almost full");
      end

endmodule

bind ifm_rx_top ifm_asserts u_asserts (
   .s2mm_clk        (s2mm_clk),
   .rst_n           (rst_n),
   .rxd_tdata       (rxd_tdata),
   .rxd_tkeep       (rxd_tkeep),
   .rxd_tlast       (rxd_tlast),
   .rxd_tvalid      (rxd_tvalid),
   .rxd_tready      (rxd_tready),
   .rxs_tdata       (rxs_tdata),
   .rxs_tvalid      (rxs_tvalid),
   .rxs_tready      (rxs_tready),
   .good_fifo_wren  (good_fifo_wren),
   .good_fifo_afull (good_fifo_afull)
);

`default_nettype wire

// File: test/ifm_tb.sv
// Directed testbench for the receive ingress buffer with frame driver, stream models and checks
`timescale 1ns/1ps
`default_nettype none

module ifm_tb;

   localparam int mode_on     = 0;
   localparam int mode_random = 1;
   localparam int mode_off    = 2;
   localparam logic [31:0] lfsr_taps = 32'h8020_0003;
   // Back-pressure test gives up after this many frames
   localparam int bp_max_frames = 80;
   // Worst case beats over all tests
   localparam int total_beats = 5 + 7 + 40 * 20 + 30 * 20 + bp_max_frames * 16;
   localparam int watchdog_cycles = total_beats * 20 + 2000;

   logic                rx_clk = 1'b0;
   logic                s2mm_clk = 1'b0;
   logic                s2mm_run = 1'b0;
   logic                rst_n;
   ifm_pkg::beat_t      data_fifo_wdata;
   logic                data_fifo_wren;
   ifm_pkg::info_t      info_fifo_wdata;
   logic                info_fifo_wren;
   logic                data_fifo_afull;
   ifm_pkg::tdata_t     rxd_tdata;
   ifm_pkg::tkeep_t     rxd_tkeep;
   logic                rxd_tlast;
   logic                rxd_tvalid;
   logic                rxd_tready = 1'b0;
   ifm_pkg::stat_data_t rxs_tdata;
   logic [3:0]          rxs_tkeep;
   logic                rxs_tlast;
   logic                rxs_tvalid;
   logic                rxs_tready = 1'b0;

   logic [31:0]         lfsr_state = 32'h8d0e;
   int                  rxd_mode = mode_on;
   int                  rxs_mode = mode_on;
   int                  beats_checked = 0;
   int                  stats_checked = 0;
   // Expected rxd beats and rxs words in order
   ifm_pkg::beat_t      exp_beats[$];
   ifm_pkg::stat_data_t exp_stats[$];

   ifm_rx_top u_dut (
      .rx_clk          (rx_clk),
      .s2mm_clk        (s2mm_clk),
      .rst_n           (rst_n),
      .data_fifo_wdata (data_fifo_wdata),
      .data_fifo_wren  (data_fifo_wren),
      .info_fifo_wdata (info_fifo_wdata),
      .info_fifo_wren  (info_fifo_wren),
      .data_fifo_afull (data_fifo_afull),
      .rxd_tdata       (rxd_tdata),
      .rxd_tkeep       (rxd_tkeep),
      .rxd_tlast       (rxd_tlast),
      .rxd_tvalid      (rxd_tvalid),
      .rxd_tready      (rxd_tready),
      .rxs_tdata       (rxs_tdata),
      .rxs_tkeep       (rxs_tkeep),
      .rxs_tlast       (rxs_tlast),
      .rxs_tvalid      (rxs_tvalid),
      .rxs_tready      (rxs_tready)
   );

   always #50 rx_clk = ~rx_clk;

   // Same period with edges 37 ns later
   always begin
      if (!s2mm_run) begin
         #37;
         s2mm_run = 1'b1;
      end
      #50;
      s2mm_clk = ~s2mm_clk;
   end

   // Galois LFSR stepped once per bit
   function automatic logic random_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ lfsr_taps;
      end
      return out;
   endfunction

   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], random_bit()};
      end
      return v;
   endfunction

   // Low n bytes valid
   function automatic ifm_pkg::tkeep_t keep_for_bytes(input int n);
      ifm_pkg::tkeep_t k;
      k = '0;
      for (int i = 0; i < n; i++) begin
         k[i] = 1'b1;
      end
      return k;
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_beat(input ifm_pkg::tdata_t exp_data, input ifm_pkg::tkeep_t exp_keep,
                             input logic exp_last, input ifm_pkg::tdata_t got_data,
                             input ifm_pkg::tkeep_t got_keep, input logic got_last);
      if (got_data !== exp_data || got_keep !== exp_keep || got_last !== exp_last) begin
         stop_on_error($sformatf(
            "mismatch at %0d ns: rxd expected %h/%h/%b, got %h/%h/%b", $time,
            exp_data, exp_keep, exp_last, got_data, got_keep, got_last));
      end
      beats_checked++;
   endtask

   task automatic check_stat(input ifm_pkg::stat_data_t exp_word,
                             input ifm_pkg::stat_data_t got_word);
      if (got_word !== exp_word) begin
         stop_on_error($sformatf("mismatch at %0d ns: rxs expected %h, got %h",
                                 $time, exp_word, got_word));
      end
      stats_checked++;
   endtask

   // Stream sink drives ready here so valid and ready hold until the next posedge
   always @(negedge s2mm_clk) begin
      if (u_dut.u_asserts.fail_count != 0) begin
         stop_on_error("a bound assertion on the DUT failed");
      end
      case (rxd_mode)
         mode_random: rxd_tready = random_bit();
         mode_off:    rxd_tready = 1'b0;
         default:     rxd_tready = 1'b1;
      endcase
      case (rxs_mode)
         mode_random: rxs_tready = random_bit();
         mode_off:    rxs_tready = 1'b0;
         default:     rxs_tready = 1'b1;
      endcase
      if (rxd_tvalid && rxd_tready) begin
         if (exp_beats.size() == 0) begin
            stop_on_error("rxd delivered a beat that the model does not expect");
         end
         check_beat(exp_beats[0][63:0], exp_beats[0][71:64], exp_beats[0][72],
                    rxd_tdata, rxd_tkeep, rxd_tlast);
         void'(exp_beats.pop_front());
      end
      if (rxs_tvalid && rxs_tready) begin
         if (exp_stats.size() == 0) begin
            stop_on_error("rxs delivered a status word that the model does not expect");
         end
         if (rxs_tkeep !== 4'hf || rxs_tlast !== 1'b1) begin
            stop_on_error($sformatf("mismatch at %0d ns: rxs keep %h last %b",
                                    $time, rxs_tkeep, rxs_tlast));
         end
         check_stat(exp_stats.pop_front(), rxs_tdata);
      end
   end

   // Beats then the info byte one cycle later with the model updated as it goes
   task automatic send_frame(input ifm_pkg::info_t code, input int nbeats, input int last_bytes);
      ifm_pkg::beat_t beat;
      ifm_pkg::tkeep_t keep;
      logic last;
      while (data_fifo_afull) begin
         @(negedge rx_clk);
      end
      for (int i = 0; i < nbeats; i++) begin
         last = i == nbeats - 1;
         keep = last ? keep_for_bytes(last_bytes) : 8'hff;
         beat = {last, keep, random_bits(64)};
         data_fifo_wdata = beat;
         data_fifo_wren  = 1'b1;
         // Only good frames reach rxd
         if (code == 8'h00) begin
            exp_beats.push_back(beat);
         end
         @(negedge rx_clk);
      end
      data_fifo_wren  = 1'b0;
      info_fifo_wdata = code;
      info_fifo_wren  = 1'b1;
      @(negedge rx_clk);
      info_fifo_wren  = 1'b0;
      exp_stats.push_back({code, 8'(nbeats), ifm_pkg::len_t'(8 * (nbeats - 1) + last_bytes)});
   endtask

   task automatic send_random_frame(input int idx);
      ifm_pkg::info_t code;
      int nbeats;
      int last_bytes;
      nbeats     = 1 + int'(random_bits(5) % 64'd20);
      last_bytes = 1 + int'(random_bits(3));
      // Even frames good and odd frames with an error code
      code = ifm_pkg::info_t'(random_bits(8));
      if (idx % 2 == 0) begin
         code = 8'h00;
      end else if (code == 8'h00) begin
         code = 8'h01;
      end
      send_frame(code, nbeats, last_bytes);
   endtask

   task automatic wait_drained();
      while (exp_beats.size() != 0 || exp_stats.size() != 0) begin
         @(negedge rx_clk);
      end
   endtask

   task automatic single_good_frame();
      send_frame(8'h00, 5, 3);
      wait_drained();
   endtask

   task automatic dropped_bad_frame();
      send_frame(8'h5a, 7, 6);
      wait_drained();
   endtask

   task automatic mixed_frames();
      for (int i = 0; i < 40; i++) begin
         send_random_frame(i);
      end
      wait_drained();
   endtask

   task automatic toggled_ready();
      rxd_mode = mode_random;
      rxs_mode = mode_random;
      for (int i = 0; i < 30; i++) begin
         send_random_frame(i);
      end
      wait_drained();
      rxd_mode = mode_on;
      rxs_mode = mode_on;
   endtask

   // Packet FIFO fills then the filter stalls and the data FIFO fills
   task automatic backpressure_fill();
      int frames;
      rxd_mode = mode_off;
      frames   = 0;
      while (!data_fifo_afull && frames < bp_max_frames) begin
         send_frame(8'h00, 16, 8);
         frames++;
      end
      if (!data_fifo_afull) begin
         stop_on_error("data_fifo_afull did not rise with rxd_tready held low");
      end
      rxd_mode = mode_on;
      wait_drained();
   endtask

   // Run limit
   initial begin
      repeat (watchdog_cycles) @(posedge rx_clk);
      stop_on_error("timeout, the DUT stopped delivering expected beats or status words");
   end

   initial begin
      rst_n           = 1'b0;
      data_fifo_wdata = '0;
      data_fifo_wren  = 1'b0;
      info_fifo_wdata = '0;
      info_fifo_wren  = 1'b0;
      repeat (4) @(negedge rx_clk);
      rst_n = 1'b1;
      // Let both reset synchronizers release
      repeat (4) @(negedge rx_clk);
      if (rxd_tvalid || rxs_tvalid || data_fifo_afull) begin
         stop_on_error("a stream valid or data_fifo_afull is high after reset");
      end
      single_good_frame();
      dropped_bad_frame();
      mixed_frames();
      toggled_ready();
      backpressure_fill();
      repeat (50) @(negedge rx_clk);
      if (rxd_tvalid || rxs_tvalid) begin
         stop_on_error("a stream is still valid after every expected item arrived");
      end
      $display("%0d rxd beats and %0d rxs words checked", beats_checked, stats_checked);
      if (u_dut.u_asserts.fail_count == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         stop_on_error("a bound assertion on the DUT failed");
      end
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/ifm_pkg.sv
hw/async_fifo.sv
hw/sync_fifo.sv
hw/ifm_fifo.sv
hw/ifm_frame_filter.sv
hw/ifm_rx_top.sv
test/ifm_asserts.sv
test/ifm_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ifm_tb -f vlog.f -o ifm_sim \
   && ./obj_dir/ifm_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && exit 0 || exit 1
